// ==== flist.f ====
+incdir+logic
logic/dcache_pkg.sv
logic/mem_pkg.sv
logic/dcache_req_stage.sv
logic/dcache_tag_array.sv
logic/dcache_data_array.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
tests/tb_clock.sv
tests/mem_model.sv
tests/dcache_tb.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - include_dirs:
      - logic
    files:
      - logic/dcache_pkg.sv
      - logic/mem_pkg.sv
      - logic/dcache_req_stage.sv
      - logic/dcache_tag_array.sv
      - logic/dcache_data_array.sv
      - logic/dcache_ctrl.sv
      - logic/dcache_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/tb_clock.sv
      - tests/mem_model.sv
      - tests/dcache_tb.sv

// ==== tests/dcache_input.txt ====
// op addr cached store_data expected_load (all hex, store data already in its lanes)
// op: 1 lw, 2 lh, 3 lb, 4 sw, 5 sh, 6 sb; expected_load is unused for stores
1 00000100 1 00000000 5a5a0100
4 00000104 1 11223344 00000000
1 00000104 1 00000000 11223344
5 0000010a 1 beef0000 00000000
6 00000109 1 0000cd00 00000000
1 00000108 1 00000000 beefcd08
5 0000010c 1 00007788 00000000
6 0000010f 1 99000000 00000000
1 0000010c 1 00000000 995a7788
4 00000200 1 a0a0a0a0 00000000
4 00001200 1 b1b1b1b1 00000000
4 00002200 1 c2c2c2c2 00000000
1 00000200 1 00000000 a0a0a0a0
1 00001200 1 00000000 b1b1b1b1
1 00002200 1 00000000 c2c2c2c2
1 00002204 1 00000000 5a5a2204
4 00003000 0 12345678 00000000
6 00003001 0 0000ee00 00000000
5 00003006 0 abcd0000 00000000
1 00003000 0 00000000 1234ee78
2 00003006 0 00000000 abcd3004
3 00003404 0 00000000 5a5a3404
1 00003000 1 00000000 1234ee78
1 00003004 1 00000000 abcd3004
2 00000106 1 00000000 11223344
3 00000103 1 00000000 5a5a0100
1 0000fffc 1 00000000 5a5afffc
1 0000011c 1 00000000 5a5a011c

// ==== tests/dcache_tb.sv ====
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_tb;

    localparam int unsigned MAX_ACCESS        = 64;
    localparam int unsigned FIELDS            = 5;
    localparam int unsigned CYCLES_PER_ACCESS = 200;
    localparam int unsigned RESET_CYCLES      = 16;

    logic                clk;
    logic                rstn;
    dcache_pkg::mem_op_t op;
    dcache_pkg::addr_t   addr;
    logic                cached;
    dcache_pkg::word_t   store_data;
    logic                taken;
    logic                ready;
    logic                data_valid;
    dcache_pkg::word_t   load_data;
    mem_pkg::mem_req_t   mem_req;
    mem_pkg::mem_rsp_t   mem_rsp;

    // five words per access in the order op, addr, cached, store data, expected load
    logic [31:0] stim [FIELDS*MAX_ACCESS];
    int unsigned num_access;
    logic        loaded = 1'b0;
    integer      seed;
    dcache_pkg::mem_op_t cur_op;

    tb_clock #(.HALF_PERIOD(4), .RESET_CYCLES(RESET_CYCLES)) u_clock (
        .clk(clk), .rstn(rstn)
    );

    mem_model u_mem (.clk(clk), .mem_req(mem_req), .mem_rsp(mem_rsp));

    dcache_top dut (
        .clk(clk), .rstn(rstn), .op(op), .addr(addr), .cached(cached),
        .store_data(store_data), .taken(taken), .ready(ready),
        .data_valid(data_valid), .load_data(load_data),
        .mem_req(mem_req), .mem_rsp(mem_rsp)
    );

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic is_store_op(input dcache_pkg::mem_op_t o);
        return (o == dcache_pkg::OP_SW) || (o == dcache_pkg::OP_SH) ||
               (o == dcache_pkg::OP_SB);
    endfunction

    // byte and half loads ask for their own size, everything else a word
    function automatic mem_pkg::mem_size_t read_size_of(input dcache_pkg::mem_op_t o);
        if (o == dcache_pkg::OP_LB) begin
            return mem_pkg::SIZE_BYTE;
        end else if (o == dcache_pkg::OP_LH) begin
            return mem_pkg::SIZE_HALF;
        end
        return mem_pkg::SIZE_WORD;
    endfunction

    // present one access and drop op once it is accepted
    task automatic send_request(input int unsigned n);
        @(posedge clk);
        #1;
        cur_op     = dcache_pkg::mem_op_t'(stim[FIELDS*n][2:0]);
        op         = cur_op;
        addr       = stim[FIELDS*n + 1];
        cached     = stim[FIELDS*n + 2][0];
        store_data = stim[FIELDS*n + 3];
        @(negedge clk);
        while (!ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        op = dcache_pkg::OP_NONE;
    endtask

    task automatic finish_store;
        @(negedge clk);
        while (!ready) begin
            check_value(data_valid, 1'b0, "data_valid during store");
            @(negedge clk);
        end
    endtask

    task automatic receive_load(input int unsigned n);
        int unsigned       hold;
        dcache_pkg::word_t first;
        @(negedge clk);
        while (!data_valid) begin
            @(negedge clk);
        end
        first = load_data;
        check_value(load_data, stim[FIELDS*n + 4], "load_data");
        // back-pressure for a random number of cycles
        hold = $unsigned($random(seed)) % 7;
        repeat (hold) begin
            @(negedge clk);
            check_value(data_valid, 1'b1, "data_valid while not taken");
            check_value(ready, 1'b0, "ready while not taken");
            check_value(load_data, first, "held load_data");
        end
        @(posedge clk);
        #1;
        taken = 1'b1;
        @(negedge clk);
        check_value(data_valid, 1'b1, "data_valid in taken cycle");
        check_value(ready, 1'b1, "ready in taken cycle");
        check_value(load_data, first, "load_data in taken cycle");
        @(posedge clk);
        #1;
        taken = 1'b0;
    endtask

    // uncached word reads carry the size of the current load
    always @(negedge clk) begin
        if (mem_req.cmd == mem_pkg::CMD_READ_WORD) begin
            check_value(mem_req.rsize, read_size_of(cur_op), "mem_req rsize");
        end
    end

    initial begin
        op         = dcache_pkg::OP_NONE;
        cur_op     = dcache_pkg::OP_NONE;
        addr       = '0;
        cached     = 1'b0;
        store_data = '0;
        taken      = 1'b0;
        seed       = 41729;
        for (int i = 0; i < FIELDS*MAX_ACCESS; i++) begin
            stim[i] = 32'hffff_ffff;
        end
        $readmemh("tests/dcache_input.txt", stim);
        num_access = 0;
        while (num_access < MAX_ACCESS && stim[FIELDS*num_access] !== 32'hffff_ffff) begin
            num_access++;
        end
        loaded = 1'b1;
        if (num_access == 0) begin
            $display("No accesses could be read from tests/dcache_input.txt");
            $display("TEST FAILED");
            $fatal(1, "empty stimulus");
        end
        wait (rstn === 1'b1);
        @(negedge clk);
        check_value(ready, 1'b1, "ready after reset");
        check_value(data_valid, 1'b0, "data_valid after reset");
        check_value(mem_req.cmd, mem_pkg::CMD_NONE, "mem_req cmd after reset");
        for (int unsigned n = 0; n < num_access; n++) begin
            send_request(n);
            if (is_store_op(dcache_pkg::mem_op_t'(stim[FIELDS*n][2:0]))) begin
                finish_store();
            end else begin
                receive_load(n);
            end
        end
        repeat (4) @(posedge clk);
        $display("TEST OK");
        $finish;
    end

    // run limit scales with the number of accesses
    initial begin
        wait (loaded === 1'b1);
        repeat (RESET_CYCLES + num_access*CYCLES_PER_ACCESS) @(posedge clk);
        $display("Timeout: the cache did not finish %0d accesses in time", num_access);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== tests/mem_model.sv ====
`timescale 1ns/1ps
`include "dcache_defs.svh"

module mem_model #(
    parameter int unsigned WORDS = 16384
) (
    input  logic              clk,
    input  mem_pkg::mem_req_t mem_req,
    output mem_pkg::mem_rsp_t mem_rsp
);

    dcache_pkg::word_t mem [WORDS];
    mem_pkg::mem_req_t req_s;
    integer            seed;
    int unsigned       delay;

    // each word starts as its own byte address xor a marker
    function automatic dcache_pkg::word_t start_pattern(input int unsigned word_idx);
        return (word_idx << 2) ^ 32'h5a5a_0000;
    endfunction

    task automatic serve(input mem_pkg::mem_req_t r);
        int unsigned idx;
        idx = (r.addr >> 2) % WORDS;
        case (r.cmd)
            mem_pkg::CMD_READ_LINE: begin
                for (int w = 0; w < `DCACHE_LINE_WORDS; w++) begin
                    mem_rsp.rline[w] = mem[idx + w];
                end
            end
            mem_pkg::CMD_WRITE_LINE: begin
                for (int w = 0; w < `DCACHE_LINE_WORDS; w++) begin
                    mem[idx + w] = r.wline[w];
                end
            end
            mem_pkg::CMD_READ_WORD: begin
                // whole aligned word whatever the size
                mem_rsp.rword = mem[idx];
            end
            mem_pkg::CMD_WRITE_WORD: begin
                for (int b = 0; b < `DCACHE_WORD_W / 8; b++) begin
                    if (r.byte_en[b]) begin
                        mem[idx][8*b +: 8] = r.wword[8*b +: 8];
                    end
                end
            end
            default: begin
            end
        endcase
        mem_rsp.done = 1'b1;
    endtask

    initial begin
        seed    = 41729;
        mem_rsp = '0;
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = start_pattern(i);
        end
        forever begin
            @(posedge clk);
            if (mem_req.cmd != mem_pkg::CMD_NONE) begin
                req_s = mem_req;
                delay = 1 + ($unsigned($random(seed)) % 6);
                repeat (delay - 1) @(posedge clk);
                #1;
                serve(req_s);
                // done is a single-cycle pulse
                @(posedge clk);
                #1;
                mem_rsp.done = 1'b0;
            end
        end
    end

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int unsigned HALF_PERIOD  = 4,
    parameter int unsigned RESET_CYCLES = 16
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // release just after an edge, like the other inputs
    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rstn = 1'b1;
    end

endmodule

// ==== logic/dcache_top.sv ====
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_top (
    input  logic                clk,
    input  logic                rstn,
    input  dcache_pkg::mem_op_t op,
    input  dcache_pkg::addr_t   addr,
    input  logic                cached,
    input  dcache_pkg::word_t   store_data,
    input  logic                taken,
    output logic                ready,
    output logic                data_valid,
    output dcache_pkg::word_t   load_data,
    output mem_pkg::mem_req_t   mem_req,
    input  mem_pkg::mem_rsp_t   mem_rsp
);

    dcache_pkg::cpu_req_t req;
    dcache_pkg::byte_en_t byte_en;
    dcache_pkg::tag_t     victim_tag;
    dcache_pkg::word_t    rword;
    dcache_pkg::line_t    victim_line;
    dcache_pkg::line_t    line_in;
    logic                 hit;
    logic                 hit_way;
    logic                 victim_way;
    logic                 victim_dirty;
    logic                 fill;
    logic                 fill_way;
    logic                 set_dirty;
    logic                 touch;
    logic                 word_wr;
    logic                 line_wr;

    dcache_req_stage u_req (
        .clk(clk), .rstn(rstn), .op(op), .addr(addr), .cached(cached),
        .store_data(store_data), .ready(ready), .req(req), .byte_en(byte_en)
    );

    dcache_tag_array u_tag (
        .clk(clk), .rstn(rstn),
        .index(req.addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W]),
        .tag(req.addr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W]),
        .fill(fill), .fill_way(fill_way), .set_dirty(set_dirty), .touch(touch),
        .hit(hit), .hit_way(hit_way), .victim_way(victim_way),
        .victim_dirty(victim_dirty), .victim_tag(victim_tag)
    );

    dcache_data_array u_data (
        .clk(clk),
        .index(req.addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W]),
        .offset(req.addr[`DCACHE_OFFSET_W-1:0]),
        .way(fill_way), .word_wr(word_wr), .byte_en(byte_en), .wdata(req.store_data),
        .line_wr(line_wr), .line_in(line_in), .rword(rword), .victim_line(victim_line)
    );

    dcache_ctrl u_ctrl (
        .clk(clk), .rstn(rstn), .req(req), .byte_en(byte_en),
        .hit(hit), .hit_way(hit_way), .victim_way(victim_way),
        .victim_dirty(victim_dirty), .victim_tag(victim_tag),
        .rword(rword), .victim_line(victim_line), .taken(taken), .mem_rsp(mem_rsp),
        .ready(ready), .data_valid(data_valid), .load_data(load_data),
        .fill(fill), .fill_way(fill_way), .set_dirty(set_dirty), .touch(touch),
        .word_wr(word_wr), .line_wr(line_wr), .line_in(line_in), .mem_req(mem_req)
    );

endmodule

// ==== logic/dcache_ctrl.sv ====
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_ctrl (
    input  logic                 clk,
    input  logic                 rstn,
    input  dcache_pkg::cpu_req_t req,
    input  dcache_pkg::byte_en_t byte_en,
    input  logic                 hit,
    input  logic                 hit_way,
    input  logic                 victim_way,
    input  logic                 victim_dirty,
    input  dcache_pkg::tag_t     victim_tag,
    input  dcache_pkg::word_t    rword,
    input  dcache_pkg::line_t    victim_line,
    input  logic                 taken,
    input  mem_pkg::mem_rsp_t    mem_rsp,
    output logic                 ready,
    output logic                 data_valid,
    output dcache_pkg::word_t    load_data,
    output logic                 fill,
    output logic                 fill_way,
    output logic                 set_dirty,
    output logic                 touch,
    output logic                 word_wr,
    output logic                 line_wr,
    output dcache_pkg::line_t    line_in,
    output mem_pkg::mem_req_t    mem_req
);

    dcache_pkg::ctrl_state_t state_q;
    dcache_pkg::ctrl_state_t state_d;

    dcache_pkg::line_t  line_q;
    dcache_pkg::word_t  word_q;
    dcache_pkg::index_t index;
    mem_pkg::mem_size_t size;
    logic               is_store;

    assign index    = req.addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
    assign is_store = req.op inside {dcache_pkg::OP_SW, dcache_pkg::OP_SH, dcache_pkg::OP_SB};

    always_comb begin
        case (req.op)
            dcache_pkg::OP_LB: size = mem_pkg::SIZE_BYTE;
            dcache_pkg::OP_LH: size = mem_pkg::SIZE_HALF;
            default:           size = mem_pkg::SIZE_WORD;
        endcase
    end

    // hit way while serving, victim way while replacing
    assign fill_way = hit ? hit_way : victim_way;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= dcache_pkg::ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == dcache_pkg::ST_REFILL && mem_rsp.done) begin
            line_q <= mem_rsp.rline;
        end
        if (state_q == dcache_pkg::ST_UNCACHED && mem_rsp.done) begin
            word_q <= mem_rsp.rword;
        end
    end

    always_comb begin
        state_d    = state_q;
        ready      = 1'b0;
        data_valid = 1'b0;
        fill       = 1'b0;
        set_dirty  = 1'b0;
        touch      = 1'b0;
        word_wr    = 1'b0;
        line_wr    = 1'b0;
        case (state_q)
            dcache_pkg::ST_IDLE: begin
                ready   = 1'b1;
                state_d = dcache_pkg::ST_LOOKUP;
            end
            dcache_pkg::ST_LOOKUP: begin
                if (req.op == dcache_pkg::OP_NONE) begin
                    ready = 1'b1;
                end else if (!req.cached) begin
                    state_d = dcache_pkg::ST_UNCACHED;
                end else if (hit) begin
                    touch = 1'b1;
                    if (is_store) begin
                        state_d = dcache_pkg::ST_STORE;
                    end else begin
                        // hold the word until the processor takes it
                        data_valid = 1'b1;
                        ready      = taken;
                    end
                end else if (victim_dirty) begin
                    state_d = dcache_pkg::ST_WRITE_BACK;
                end else begin
                    state_d = dcache_pkg::ST_REFILL;
                end
            end
            dcache_pkg::ST_STORE: begin
                word_wr   = 1'b1;
                set_dirty = 1'b1;
                ready     = 1'b1;
                state_d   = dcache_pkg::ST_LOOKUP;
            end
            dcache_pkg::ST_WRITE_BACK: begin
                if (mem_rsp.done) begin
                    state_d = dcache_pkg::ST_REFILL;
                end
            end
            dcache_pkg::ST_REFILL: begin
                if (mem_rsp.done) begin
                    state_d = dcache_pkg::ST_REFILL_WRITE;
                end
            end
            dcache_pkg::ST_REFILL_WRITE: begin
                // lookup again, now a hit
                line_wr = 1'b1;
                fill    = 1'b1;
                state_d = dcache_pkg::ST_LOOKUP;
            end
            dcache_pkg::ST_UNCACHED: begin
                if (mem_rsp.done) begin
                    state_d = is_store ? dcache_pkg::ST_IDLE : dcache_pkg::ST_UNCACHED_DONE;
                end
            end
            dcache_pkg::ST_UNCACHED_DONE: begin
                data_valid = 1'b1;
                if (taken) begin
                    ready   = 1'b1;
                    state_d = dcache_pkg::ST_LOOKUP;
                end
            end
            default: begin
                state_d = dcache_pkg::ST_IDLE;
            end
        endcase
    end

    assign line_in   = line_q;
    assign load_data = (state_q == dcache_pkg::ST_UNCACHED_DONE) ? word_q : rword;

    always_comb begin
        mem_req.cmd     = mem_pkg::CMD_NONE;
        mem_req.addr    = req.addr;
        mem_req.wline   = victim_line;
        mem_req.wword   = req.store_data;
        mem_req.byte_en = byte_en;
        mem_req.rsize   = size;
        case (state_q)
            dcache_pkg::ST_WRITE_BACK: begin
                mem_req.cmd  = mem_pkg::CMD_WRITE_LINE;
                mem_req.addr = {victim_tag, index, {`DCACHE_OFFSET_W{1'b0}}};
            end
            dcache_pkg::ST_REFILL: begin
                mem_req.cmd  = mem_pkg::CMD_READ_LINE;
                mem_req.addr = {req.addr[`DCACHE_ADDR_W-1:`DCACHE_OFFSET_W],
                                {`DCACHE_OFFSET_W{1'b0}}};
            end
            dcache_pkg::ST_UNCACHED: begin
                mem_req.cmd = is_store ? mem_pkg::CMD_WRITE_WORD : mem_pkg::CMD_READ_WORD;
            end
            default: begin
                mem_req.cmd = mem_pkg::CMD_NONE;
            end
        endcase
    end

endmodule

// ==== logic/dcache_data_array.sv ====
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_data_array (
    input  logic                 clk,
    input  dcache_pkg::index_t   index,
    input  dcache_pkg::offset_t  offset,
    input  logic                 way,
    input  logic                 word_wr,
    input  dcache_pkg::byte_en_t byte_en,
    input  dcache_pkg::word_t    wdata,
    input  logic                 line_wr,
    input  dcache_pkg::line_t    line_in,
    output dcache_pkg::word_t    rword,
    output dcache_pkg::line_t    victim_line
);

    localparam int unsigned WORD_SEL_W = $clog2(`DCACHE_LINE_WORDS);

    dcache_pkg::line_t lines_q [`DCACHE_WAYS][`DCACHE_SETS];

    logic [WORD_SEL_W-1:0] word_sel;

    // drop the byte-in-word bits
    assign word_sel = offset[`DCACHE_OFFSET_W-1 -: WORD_SEL_W];

    always_ff @(posedge clk) begin
        if (line_wr) begin
            lines_q[way][index] <= line_in;
        end else if (word_wr) begin
            for (int b = 0; b < `DCACHE_WORD_W/8; b++) begin
                if (byte_en[b]) begin
                    lines_q[way][index][word_sel][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    assign rword       = lines_q[way][index][word_sel];
    assign victim_line = lines_q[way][index];

endmodule

// ==== logic/dcache_tag_array.sv ====
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_tag_array (
    input  logic               clk,
    input  logic               rstn,
    input  dcache_pkg::index_t index,
    input  dcache_pkg::tag_t   tag,
    input  logic               fill,
    input  logic               fill_way,
    input  logic               set_dirty,
    input  logic               touch,
    output logic               hit,
    output logic               hit_way,
    output logic               victim_way,
    output logic               victim_dirty,
    output dcache_pkg::tag_t   victim_tag
);

    dcache_pkg::tag_t tag_q [`DCACHE_WAYS][`DCACHE_SETS];
    logic [`DCACHE_SETS-1:0] valid_q [`DCACHE_WAYS];
    logic [`DCACHE_SETS-1:0] dirty_q [`DCACHE_WAYS];
    // last used way of each set
    logic [`DCACHE_SETS-1:0] lru_q;

    logic [`DCACHE_WAYS-1:0] way_hit;

    always_comb begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            way_hit[w] = valid_q[w][index] && (tag_q[w][index] == tag);
        end
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];

    assign victim_way   = ~lru_q[index];
    assign victim_dirty = valid_q[victim_way][index] && dirty_q[victim_way][index];
    assign victim_tag   = tag_q[victim_way][index];

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_q[fill_way][index] <= tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int w = 0; w < `DCACHE_WAYS; w++) begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
            end
            lru_q <= '0;
        end else begin
            // a refilled line starts clean
            if (fill) begin
                valid_q[fill_way][index] <= 1'b1;
                dirty_q[fill_way][index] <= 1'b0;
            end
            if (set_dirty) begin
                dirty_q[hit_way][index] <= 1'b1;
            end
            if (touch) begin
                lru_q[index] <= hit_way;
            end
        end
    end

endmodule

// ==== logic/dcache_req_stage.sv ====
`timescale 1ns/1ps

module dcache_req_stage (
    input  logic                 clk,
    input  logic                 rstn,
    input  dcache_pkg::mem_op_t  op,
    input  dcache_pkg::addr_t    addr,
    input  logic                 cached,
    input  dcache_pkg::word_t    store_data,
    input  logic                 ready,
    output dcache_pkg::cpu_req_t req,
    output dcache_pkg::byte_en_t byte_en
);

    dcache_pkg::mem_op_t op_q;
    dcache_pkg::addr_t   addr_q;
    logic                cached_q;
    dcache_pkg::word_t   data_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            op_q <= dcache_pkg::OP_NONE;
        end else if (ready) begin
            op_q <= op;
        end
    end

    always_ff @(posedge clk) begin
        if (ready) begin
            addr_q   <= addr;
            cached_q <= cached;
            data_q   <= store_data;
        end
    end

    assign req.op         = op_q;
    assign req.addr       = addr_q;
    assign req.cached     = cached_q;
    assign req.store_data = data_q;

    // lane enables from size and low address bits
    always_comb begin
        case (op_q)
            dcache_pkg::OP_LW, dcache_pkg::OP_SW: byte_en = 4'b1111;
            dcache_pkg::OP_LH, dcache_pkg::OP_SH: byte_en = addr_q[1] ? 4'b1100 : 4'b0011;
            dcache_pkg::OP_LB, dcache_pkg::OP_SB: byte_en = 4'b0001 << addr_q[1:0];
            default: byte_en = 4'b0000;
        endcase
    end

endmodule

// ==== logic/mem_pkg.sv ====
package mem_pkg;

    typedef enum logic [2:0] {
        CMD_NONE, CMD_READ_LINE, CMD_WRITE_LINE, CMD_READ_WORD, CMD_WRITE_WORD
    } mem_cmd_t;

    // uncached read size
    typedef enum logic [1:0] {
        SIZE_BYTE, SIZE_HALF, SIZE_WORD
    } mem_size_t;

    typedef struct packed {
        mem_cmd_t            cmd;
        dcache_pkg::addr_t   addr;
        dcache_pkg::line_t   wline;
        dcache_pkg::word_t   wword;
        dcache_pkg::byte_en_t byte_en;
        mem_size_t           rsize;
    } mem_req_t;

    typedef struct packed {
        logic              done;
        dcache_pkg::line_t rline;
        dcache_pkg::word_t rword;
    } mem_rsp_t;

endpackage

// ==== logic/dcache_pkg.sv ====
`include "dcache_defs.svh"

package dcache_pkg;

    typedef logic [`DCACHE_ADDR_W-1:0] addr_t;
    typedef logic [`DCACHE_WORD_W-1:0] word_t;
    typedef logic [`DCACHE_LINE_WORDS-1:0][`DCACHE_WORD_W-1:0] line_t;

    typedef logic [`DCACHE_TAG_W-1:0] tag_t;
    typedef logic [`DCACHE_INDEX_W-1:0] index_t;
    typedef logic [`DCACHE_OFFSET_W-1:0] offset_t;

    typedef logic [`DCACHE_WORD_W/8-1:0] byte_en_t;

    typedef enum logic [2:0] {
        OP_NONE, OP_LW, OP_LH, OP_LB, OP_SW, OP_SH, OP_SB
    } mem_op_t;

    typedef enum logic [2:0] {
        ST_IDLE, ST_LOOKUP, ST_STORE, ST_WRITE_BACK,
        ST_REFILL, ST_REFILL_WRITE, ST_UNCACHED, ST_UNCACHED_DONE
    } ctrl_state_t;

    // store data arrives already placed in its byte lanes
    typedef struct packed {
        mem_op_t op;
        addr_t   addr;
        logic    cached;
        word_t   store_data;
    } cpu_req_t;

endpackage

// ==== logic/dcache_defs.svh ====
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// address and data widths
`define DCACHE_ADDR_W 32
`define DCACHE_WORD_W 32

// line geometry
`define DCACHE_LINE_WORDS 8
`define DCACHE_SETS 128

// address split into tag, index and offset from the top
`define DCACHE_OFFSET_W 5
`define DCACHE_INDEX_W 7
`define DCACHE_TAG_W 20

// two ways, the lru and hit logic rely on it
`define DCACHE_WAYS 2

`endif
